/* src/ask_link_pkg.sv */
`default_nettype none

package ask_link_pkg;

    typedef logic signed [17:0] sample_t;
    typedef logic [1:0] sym_t;
    typedef logic signed [39:0] acc_t;
    typedef logic [3:0] phase_t;
    typedef logic [15:0] lfsr_t;

    localparam sample_t SYM_UNIT = 18'sd4096;
    localparam int BLOCK_LOG = 6;
    localparam lfsr_t LFSR_SEED = 16'hACE1;

    // Ideal 4-ASK levels
    localparam sample_t LVL_N3 = sample_t'(-3 * SYM_UNIT);
    localparam sample_t LVL_N1 = sample_t'(-SYM_UNIT);
    localparam sample_t LVL_P1 = SYM_UNIT;
    localparam sample_t LVL_P3 = sample_t'(3 * SYM_UNIT);

    typedef struct packed {
        sample_t ref_level;
        sample_t dc_err;
        acc_t    mse;
    } meas_t;

    // Gray map, 00 -> -3a, 01 -> -a, 11 -> +a, 10 -> +3a
    function automatic sample_t gray_level(input sym_t sym);
        sample_t lvl;
        case (sym)
            2'b00:   lvl = LVL_N3;
            2'b01:   lvl = LVL_N1;
            2'b11:   lvl = LVL_P1;
            default: lvl = LVL_P3;
        endcase
        return lvl;
    endfunction

endpackage

`default_nettype wire

/* src/clk_en_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_en_gen (
    input  wire  clk,
    input  wire  rst_n,
    output logic sam_en,
    output logic sym_en
);

    ask_link_pkg::phase_t phase;

    // Free-running phase within one symbol period
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // Four samples per symbol, both enables on the last phase
    always_comb begin
        sam_en = (phase[1:0] == 2'd3);
        sym_en = (phase == 4'd15);
    end

endmodule

`default_nettype wire

/* src/lfsr_sym_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module lfsr_sym_gen (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       sym_en,
    output ask_link_pkg::sym_t        tx_sym,
    output logic                      tx_strobe
);

    ask_link_pkg::lfsr_t lfsr;
    ask_link_pkg::lfsr_t step1;
    logic                fb1;
    logic                fb2;

    // Fibonacci taps 16, 14, 13, 11
    assign fb1 = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    assign step1 = {lfsr[14:0], fb1};
    assign fb2 = step1[15] ^ step1[13] ^ step1[12] ^ step1[10];

    // Two shifts per symbol, first new bit lands in the MSB
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr <= ask_link_pkg::LFSR_SEED;
            tx_sym <= '0;
            tx_strobe <= 1'b0;
        end else begin
            tx_strobe <= sym_en;
            if (sym_en) begin
                lfsr <= {step1[14:0], fb2};
                tx_sym <= {fb1, fb2};
            end
        end
    end

endmodule

`default_nettype wire

/* src/ask_modulator.sv */
`timescale 1ns/1ps
`default_nettype none

module ask_modulator (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       sam_en,
    input  wire                       sym_en,
    input  wire ask_link_pkg::sym_t   tx_sym,
    output ask_link_pkg::sample_t     tx_sample
);

    ask_link_pkg::sample_t lvl_q;
    logic                  sym_vld;

    // Symbol-rate mapping stage; tx_sym carries no symbol before the first sym_en
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lvl_q <= '0;
            sym_vld <= 1'b0;
        end else if (sym_en) begin
            lvl_q <= sym_vld ? ask_link_pkg::gray_level(tx_sym) : '0;
            sym_vld <= 1'b1;
        end
    end

    // Upsample by 4, three zero samples follow each level
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_sample <= '0;
        end else if (sam_en) begin
            if (sym_en) begin
                tx_sample <= lvl_q;
            end else begin
                tx_sample <= '0;
            end
        end
    end

endmodule

`default_nettype wire

/* src/chan_model.sv */
`timescale 1ns/1ps
`default_nettype none

module chan_model #(
    parameter int                    CHAN_SHIFT  = 1,
    parameter ask_link_pkg::sample_t CHAN_OFFSET = 18'sd200
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          sam_en,
    input  wire ask_link_pkg::sample_t   tx_sample,
    output ask_link_pkg::sample_t        rx_sample
);

    ask_link_pkg::sample_t scaled;

    // Channel gain as an arithmetic right shift
    assign scaled = tx_sample >>> CHAN_SHIFT;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_sample <= '0;
        end else if (sam_en) begin
            // DC offset added after the gain
            rx_sample <= scaled + CHAN_OFFSET;
        end
    end

endmodule

`default_nettype wire

/* src/sym_sampler.sv */
`timescale 1ns/1ps
`default_nettype none

module sym_sampler (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          sam_en,
    input  wire                          sym_en,
    input  wire ask_link_pkg::sample_t   rx_sample,
    output ask_link_pkg::sample_t        dec_var,
    output logic                         dec_strobe
);

    // Tracks the symbol slot through modulator and channel registers
    logic [1:0] slot;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot <= '0;
            dec_var <= '0;
            dec_strobe <= 1'b0;
        end else begin
            dec_strobe <= 1'b0;
            if (sam_en) begin
                slot <= {slot[0], sym_en};
                if (slot[1]) begin
                    dec_var <= rx_sample;
                    dec_strobe <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/ref_level_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module ref_level_gen #(
    parameter ask_link_pkg::sample_t REF_INIT = 18'sd4096
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          dec_strobe,
    input  wire ask_link_pkg::sample_t   dec_var,
    output ask_link_pkg::sample_t        ref_level
);

    ask_link_pkg::acc_t                 mag_sum;
    ask_link_pkg::acc_t                 sum_next;
    ask_link_pkg::sample_t              mag;
    logic [ask_link_pkg::BLOCK_LOG-1:0] dec_cnt;

    always_comb begin
        mag = dec_var[17] ? -dec_var : dec_var;
        sum_next = mag_sum + ask_link_pkg::acc_t'(mag);
    end

    // Mean magnitude over one block becomes the new threshold
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mag_sum <= '0;
            dec_cnt <= '0;
            ref_level <= REF_INIT;
        end else if (dec_strobe) begin
            dec_cnt <= dec_cnt + 1'b1;
            if (&dec_cnt) begin
                ref_level <= ask_link_pkg::sample_t'(sum_next >>> ask_link_pkg::BLOCK_LOG);
                mag_sum <= '0;
            end else begin
                mag_sum <= sum_next;
            end
        end
    end

endmodule

`default_nettype wire

/* src/ask_slicer.sv */
`timescale 1ns/1ps
`default_nettype none

module ask_slicer #(
    parameter int CHAN_SHIFT = 1
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          dec_strobe,
    input  wire ask_link_pkg::sample_t   dec_var,
    input  wire ask_link_pkg::sample_t   ref_level,
    output ask_link_pkg::sym_t           rx_sym,
    output ask_link_pkg::sample_t        recon,
    output logic                         rx_strobe
);

    ask_link_pkg::sample_t neg_ref;
    ask_link_pkg::sym_t    dec_sym;

    always_comb begin
        neg_ref = -ref_level;
        if (dec_var >= ref_level) begin
            dec_sym = 2'b10;
        end else if (dec_var >= 0) begin
            dec_sym = 2'b11;
        end else if (dec_var > neg_ref) begin
            dec_sym = 2'b01;
        end else begin
            dec_sym = 2'b00;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_sym <= '0;
            recon <= '0;
            rx_strobe <= 1'b0;
        end else begin
            rx_strobe <= dec_strobe;
            if (dec_strobe) begin
                rx_sym <= dec_sym;
                // Ideal level at the channel gain, offset left out
                recon <= ask_link_pkg::gray_level(dec_sym) >>> CHAN_SHIFT;
            end
        end
    end

endmodule

`default_nettype wire

/* src/err_meter.sv */
`timescale 1ns/1ps
`default_nettype none

module err_meter (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          rx_strobe,
    input  wire ask_link_pkg::sample_t   dec_var,
    input  wire ask_link_pkg::sample_t   recon,
    input  wire ask_link_pkg::sample_t   ref_level,
    output ask_link_pkg::meas_t          meas,
    output logic                         meas_valid
);

    ask_link_pkg::sample_t              err_q;
    logic                               acc_en;
    ask_link_pkg::acc_t                 dc_sum;
    ask_link_pkg::acc_t                 sq_sum;
    ask_link_pkg::acc_t                 dc_next;
    ask_link_pkg::acc_t                 sq_next;
    logic [ask_link_pkg::BLOCK_LOG-1:0] dec_cnt;

    always_comb begin
        dc_next = dc_sum + ask_link_pkg::acc_t'(err_q);
        sq_next = sq_sum + ask_link_pkg::acc_t'(err_q) * ask_link_pkg::acc_t'(err_q);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            err_q <= '0;
            acc_en <= 1'b0;
            dc_sum <= '0;
            sq_sum <= '0;
            dec_cnt <= '0;
            meas <= '0;
            meas_valid <= 1'b0;
        end else begin
            // Error of the decision just made
            acc_en <= rx_strobe;
            if (rx_strobe) begin
                err_q <= dec_var - recon;
            end
            meas_valid <= 1'b0;
            if (acc_en) begin
                dec_cnt <= dec_cnt + 1'b1;
                if (&dec_cnt) begin
                    meas.ref_level <= ref_level;
                    meas.dc_err <= ask_link_pkg::sample_t'(dc_next >>> ask_link_pkg::BLOCK_LOG);
                    meas.mse <= sq_next >>> ask_link_pkg::BLOCK_LOG;
                    meas_valid <= 1'b1;
                    dc_sum <= '0;
                    sq_sum <= '0;
                end else begin
                    dc_sum <= dc_next;
                    sq_sum <= sq_next;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/ask_link_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ask_link_top #(
    parameter int                    CHAN_SHIFT  = 1,
    parameter ask_link_pkg::sample_t CHAN_OFFSET = 18'sd200,
    parameter ask_link_pkg::sample_t REF_INIT    =
        ask_link_pkg::sample_t'((2 * ask_link_pkg::SYM_UNIT) >>> CHAN_SHIFT)
) (
    input  wire                    clk,
    input  wire                    rst_n,
    output ask_link_pkg::sym_t     tx_sym,
    output logic                   tx_strobe,
    output ask_link_pkg::sym_t     rx_sym,
    output logic                   rx_strobe,
    output ask_link_pkg::meas_t    meas,
    output logic                   meas_valid
);

    logic                  sam_en;
    logic                  sym_en;
    ask_link_pkg::sample_t tx_sample;
    ask_link_pkg::sample_t rx_sample;
    ask_link_pkg::sample_t dec_var;
    logic                  dec_strobe;
    ask_link_pkg::sample_t ref_level;
    ask_link_pkg::sample_t recon;

    clk_en_gen clk_en_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .sam_en (sam_en),
        .sym_en (sym_en)
    );

    // Transmit side
    lfsr_sym_gen lfsr_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .sym_en    (sym_en),
        .tx_sym    (tx_sym),
        .tx_strobe (tx_strobe)
    );

    ask_modulator mod_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .sam_en    (sam_en),
        .sym_en    (sym_en),
        .tx_sym    (tx_sym),
        .tx_sample (tx_sample)
    );

    chan_model #(
        .CHAN_SHIFT  (CHAN_SHIFT),
        .CHAN_OFFSET (CHAN_OFFSET)
    ) chan_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .sam_en    (sam_en),
        .tx_sample (tx_sample),
        .rx_sample (rx_sample)
    );

    // Receive side
    sym_sampler sampler_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .sam_en     (sam_en),
        .sym_en     (sym_en),
        .rx_sample  (rx_sample),
        .dec_var    (dec_var),
        .dec_strobe (dec_strobe)
    );

    ref_level_gen #(
        .REF_INIT (REF_INIT)
    ) ref_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec_strobe (dec_strobe),
        .dec_var    (dec_var),
        .ref_level  (ref_level)
    );

    ask_slicer #(
        .CHAN_SHIFT (CHAN_SHIFT)
    ) slicer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec_strobe (dec_strobe),
        .dec_var    (dec_var),
        .ref_level  (ref_level),
        .rx_sym     (rx_sym),
        .recon      (recon),
        .rx_strobe  (rx_strobe)
    );

    err_meter meter_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_strobe  (rx_strobe),
        .dec_var    (dec_var),
        .recon      (recon),
        .ref_level  (ref_level),
        .meas       (meas),
        .meas_valid (meas_valid)
    );

endmodule

`default_nettype wire

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int HALF_PERIOD = 5
) (
    output logic clk
);

    // 10 ns period, first rising edge at 5 ns
    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* tb/ask_link_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ask_link_tb;

    localparam int     CHAN_SHIFT  = 1;
    localparam longint CHAN_OFFSET = 200;
    localparam longint UNIT        = ask_link_pkg::SYM_UNIT;
    localparam longint REF_INIT    = (2 * UNIT) >>> CHAN_SHIFT;
    localparam int     BLOCK_LOG   = ask_link_pkg::BLOCK_LOG;
    localparam int     BLOCK_LEN   = 1 << BLOCK_LOG;
    localparam int     NUM_BLOCKS  = 6;
    localparam int     CYCLE_LIMIT = BLOCK_LEN * NUM_BLOCKS * 16 + 200;

    logic                clk;
    logic                rst_n;
    ask_link_pkg::sym_t  tx_sym;
    logic                tx_strobe;
    ask_link_pkg::sym_t  rx_sym;
    logic                rx_strobe;
    ask_link_pkg::meas_t meas;
    logic                meas_valid;

    // Reference model state
    ask_link_pkg::lfsr_t  lfsr_state = ask_link_pkg::LFSR_SEED;
    ask_link_pkg::phase_t sym_phase = '0;
    logic                 sym_locked = 1'b0;
    ask_link_pkg::sym_t   sent_q[$];
    longint               model_ref = REF_INIT;
    longint               mag_sum = 0;
    longint               dc_sum = 0;
    longint               sq_sum = 0;
    int                   blk_cnt = 0;
    int                   rx_cnt = 0;
    longint               exp_ref_q[$];
    longint               exp_dc_q[$];
    longint               exp_mse_q[$];

    int cycles = 0;
    int meas_cnt = 0;
    int src_errs = 0;
    int link_errs = 0;
    int ref_errs = 0;
    int dc_errs = 0;
    int mse_errs = 0;
    int reset_errs = 0;
    int timeout_errs = 0;

    tb_clk_gen clk_gen_i (
        .clk (clk)
    );

    ask_link_top #(
        .CHAN_SHIFT  (CHAN_SHIFT),
        .CHAN_OFFSET (ask_link_pkg::sample_t'(CHAN_OFFSET)),
        .REF_INIT    (ask_link_pkg::sample_t'(REF_INIT))
    ) dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .tx_sym     (tx_sym),
        .tx_strobe  (tx_strobe),
        .rx_sym     (rx_sym),
        .rx_strobe  (rx_strobe),
        .meas       (meas),
        .meas_valid (meas_valid)
    );

    // Two Fibonacci steps with the first new bit as the symbol MSB
    task automatic step_lfsr(output ask_link_pkg::sym_t sym);
        logic fb;
        for (int i = 0; i < 2; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            sym[1 - i] = fb;
        end
    endtask

    function automatic longint ideal_level(input ask_link_pkg::sym_t sym);
        case (sym)
            2'b00:   return -3 * UNIT;
            2'b01:   return -UNIT;
            2'b11:   return UNIT;
            default: return 3 * UNIT;
        endcase
    endfunction

    function automatic ask_link_pkg::sym_t decide(input longint dv, input longint thr);
        if (dv >= thr) begin
            return 2'b10;
        end else if (dv >= 0) begin
            return 2'b11;
        end else if (dv > -thr) begin
            return 2'b01;
        end
        return 2'b00;
    endfunction

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // Outputs are registered on the rising edge and sampled here
    always @(negedge clk) begin
        ask_link_pkg::sym_t exp_sym;
        ask_link_pkg::sym_t dec;
        longint             dv;
        longint             rec;
        // One symbol every 16 cycles once the first one is out
        if (sym_locked) begin
            sym_phase = sym_phase + 1'b1;
            assert (tx_strobe == (sym_phase == '0)) else begin
                $display("Error symbol period: expected tx_strobe %0b, actual %0b",
                         sym_phase == '0, tx_strobe);
                src_errs++;
            end
        end else begin
            sym_locked = tx_strobe;
        end
        if (tx_strobe) begin
            step_lfsr(exp_sym);
            sent_q.push_back(exp_sym);
            assert (tx_sym == exp_sym) else begin
                $display("Error source: expected %0d, actual %0d", exp_sym, tx_sym);
                src_errs++;
            end
        end
        if (rx_strobe) begin
            rx_cnt++;
            // Two fill decisions see only the channel offset
            if (rx_cnt <= 2) begin
                dv = CHAN_OFFSET;
            end else begin
                exp_sym = sent_q.pop_front();
                dv = (ideal_level(exp_sym) >>> CHAN_SHIFT) + CHAN_OFFSET;
                assert (rx_sym == exp_sym) else begin
                    $display("Error link: expected %0d, actual %0d", exp_sym, rx_sym);
                    link_errs++;
                end
            end
            dec = decide(dv, model_ref);
            rec = ideal_level(dec) >>> CHAN_SHIFT;
            mag_sum += (dv < 0) ? -dv : dv;
            dc_sum += dv - rec;
            sq_sum += (dv - rec) * (dv - rec);
            blk_cnt++;
            if (blk_cnt == BLOCK_LEN) begin
                model_ref = mag_sum >>> BLOCK_LOG;
                exp_ref_q.push_back(model_ref);
                exp_dc_q.push_back(dc_sum >>> BLOCK_LOG);
                exp_mse_q.push_back(sq_sum >>> BLOCK_LOG);
                mag_sum = 0;
                dc_sum = 0;
                sq_sum = 0;
                blk_cnt = 0;
            end
        end
        if (meas_valid) begin
            meas_cnt++;
            if (exp_ref_q.size() == 0) begin
                $display("meas_valid came before a block of decisions was complete");
                ref_errs++;
            end else begin
                rec = exp_ref_q.pop_front();
                assert (longint'(meas.ref_level) == rec) else begin
                    $display("Error ref_level: expected %0d, actual %0d", rec, meas.ref_level);
                    ref_errs++;
                end
                rec = exp_dc_q.pop_front();
                assert (longint'(meas.dc_err) == rec) else begin
                    $display("Error dc_err: expected %0d, actual %0d", rec, meas.dc_err);
                    dc_errs++;
                end
                rec = exp_mse_q.pop_front();
                assert (longint'(meas.mse) == rec) else begin
                    $display("Error mse: expected %0d, actual %0d", rec, meas.mse);
                    mse_errs++;
                end
            end
        end
    end

    initial begin
        logic tx_seen;
        int   total;
        rst_n = 1'b0;
        tx_seen = 1'b0;
        repeat (3) begin
            @(negedge clk);
            assert (!rx_strobe && !meas_valid) else begin
                $display("rx_strobe or meas_valid was high during reset");
                reset_errs++;
            end
        end
        rst_n = 1'b1;
        for (int i = 0; i < 16 && !tx_seen; i++) begin
            @(negedge clk);
            tx_seen = tx_strobe;
            assert (!rx_strobe && !meas_valid) else begin
                $display("rx_strobe or meas_valid was high before the first tx_strobe");
                reset_errs++;
            end
        end
        if (!tx_seen) begin
            $display("No tx_strobe within 16 cycles after reset");
            reset_errs++;
        end
        while (meas_cnt < NUM_BLOCKS && cycles < CYCLE_LIMIT) begin
            @(negedge clk);
        end
        if (meas_cnt < NUM_BLOCKS) begin
            $display("Timeout after %0d cycles with %0d of %0d blocks measured",
                     cycles, meas_cnt, NUM_BLOCKS);
            timeout_errs++;
        end
        total = src_errs + link_errs + ref_errs + dc_errs + mse_errs + reset_errs + timeout_errs;
        $display("Failed checks: source %0d, link %0d, ref_level %0d, dc_err %0d, mse %0d, %s",
                 src_errs, link_errs, ref_errs, dc_errs, mse_errs,
                 $sformatf("reset %0d, timeout %0d", reset_errs, timeout_errs));
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* ask_link_top.f */
src/ask_link_pkg.sv
src/clk_en_gen.sv
src/lfsr_sym_gen.sv
src/ask_modulator.sv
src/chan_model.sv
src/sym_sampler.sv
src/ref_level_gen.sv
src/ask_slicer.sv
src/err_meter.sv
src/ask_link_top.sv
tb/tb_clk_gen.sv
tb/ask_link_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module ask_link_tb \
    -f ask_link_top.f -o ask_link_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/ask_link_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0
